//--- source/cpu_pkg.sv
package cpu_pkg;

	// rv32i base opcodes
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_OPIMM  = 7'b0010011;
	localparam logic [6:0] OP_OP     = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_r_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} inst_i_t;

	// store and branch share this split immediate layout
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} inst_s_t;

	typedef union packed {
		inst_r_t     r;
		inst_i_t     i;
		inst_s_t     s;
		logic [31:0] raw;
	} inst_t;

	typedef struct packed {
		logic [31:0] pc;
		inst_t       inst;
	} fs_to_ds_bus_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] op_a;
		logic [31:0] op_b;
		logic [31:0] store_data;
		logic [31:0] br_imm;
		alu_op_e     alu_op;
		logic        is_branch;
		logic        is_jal;
		logic        is_load;
		logic        is_store;
		logic        is_ebreak;
		logic [4:0]  rd;
		logic        rf_we;
	} ds_to_es_bus_t;

	typedef struct packed {
		logic [31:0] alu_result;
		logic [31:0] store_data;
		logic [31:0] next_pc;
		logic        is_load;
		logic        is_store;
		logic        is_ebreak;
		logic [4:0]  rd;
		logic        rf_we;
	} es_to_ms_bus_t;

	typedef struct packed {
		logic [31:0] wdata;
		logic [4:0]  rd;
		logic        rf_we;
		logic [31:0] next_pc;
		logic        is_ebreak;
	} ms_to_ws_bus_t;

	typedef struct packed {
		logic        we;
		logic [4:0]  addr;
		logic [31:0] data;
	} rf_write_t;

	typedef struct packed {
		logic        redirect;
		logic [31:0] pc;
		logic        halt;
	} ws_to_fs_t;

endpackage

//--- source/cpu_ifu_stage.sv
`timescale 1ns/1ns

module cpu_ifu_stage import cpu_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  logic          clock,
	input  logic          reset_i,
	input  ws_to_fs_t     ws_to_fs_i,
	input  logic          inst_pvalid_i,
	input  logic [31:0]   inst_prdata_i,
	input  logic          ds_allowin_i,
	output logic [31:0]   inst_paddr_o,
	output logic          inst_psel_o,
	output logic          fs_to_ds_valid_o,
	output fs_to_ds_bus_t fs_to_ds_bus_o,
	output logic          halted_o
);
	localparam logic [1:0] FS_IDLE = 2'd0;
	localparam logic [1:0] FS_REQ  = 2'd1;
	localparam logic [1:0] FS_WAIT = 2'd2;
	localparam logic [1:0] FS_HALT = 2'd3;

	logic [1:0]    fs_state;
	logic [31:0]   fs_pc;
	logic          fs_valid;
	fs_to_ds_bus_t fs_bus;
	logic          inst_done;

	assign inst_done = inst_psel_o & inst_pvalid_i;

	always_ff @(posedge clock) begin
		if (reset_i) begin
			fs_state <= FS_IDLE;
			fs_pc    <= RESET_PC;
		end else begin
			case (fs_state)
				FS_IDLE: fs_state <= FS_REQ;
				FS_REQ: begin
					if (inst_done) begin
						fs_state <= FS_WAIT;
					end
				end
				// one instruction in flight until writeback hands back the pc
				FS_WAIT: begin
					if (ws_to_fs_i.redirect) begin
						if (ws_to_fs_i.halt) begin
							fs_state <= FS_HALT;
						end else begin
							fs_state <= FS_REQ;
							fs_pc    <= ws_to_fs_i.pc;
						end
					end
				end
				default: fs_state <= FS_HALT;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset_i) begin
			fs_valid <= 1'b0;
		end else if (inst_done) begin
			fs_valid <= 1'b1;
		end else if (ds_allowin_i) begin
			fs_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (inst_done) begin
			fs_bus.pc   <= fs_pc;
			fs_bus.inst <= inst_prdata_i;
		end
	end

	assign inst_psel_o      = (fs_state == FS_REQ);
	assign inst_paddr_o     = fs_pc;
	assign fs_to_ds_valid_o = fs_valid;
	assign fs_to_ds_bus_o   = fs_bus;
	assign halted_o         = (fs_state == FS_HALT);

endmodule

//--- source/cpu_id_stage.sv
`timescale 1ns/1ns

module cpu_id_stage import cpu_pkg::*; (
	input  logic          clock,
	input  logic          reset_i,
	input  logic          fs_to_ds_valid_i,
	input  fs_to_ds_bus_t fs_to_ds_bus_i,
	input  logic [31:0]   rs1_data_i,
	input  logic [31:0]   rs2_data_i,
	input  logic          es_allowin_i,
	output logic          ds_allowin_o,
	output logic [4:0]    rs1_addr_o,
	output logic [4:0]    rs2_addr_o,
	output logic          ds_to_es_valid_o,
	output ds_to_es_bus_t ds_to_es_bus_o
);
	logic          ds_valid;
	logic          ds_ready_go;
	fs_to_ds_bus_t ds_bus;
	inst_t         inst;
	logic [31:0]   imm_i;
	logic [31:0]   imm_s;
	logic [31:0]   imm_b;
	logic [31:0]   imm_u;
	logic [31:0]   imm_j;
	ds_to_es_bus_t dec;

	assign ds_ready_go  = 1'b1;
	assign ds_allowin_o = !ds_valid || (ds_ready_go && es_allowin_i);

	always_ff @(posedge clock) begin
		if (reset_i) begin
			ds_valid <= 1'b0;
		end else if (ds_allowin_o) begin
			ds_valid <= fs_to_ds_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		if (fs_to_ds_valid_i && ds_allowin_o) begin
			ds_bus <= fs_to_ds_bus_i;
		end
	end

	assign inst = ds_bus.inst;

	assign rs1_addr_o = inst.r.rs1;
	assign rs2_addr_o = inst.r.rs2;

	assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
	assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
	// b-type reshuffles the s-type immediate fields
	assign imm_b = {{19{inst.s.imm_hi[6]}}, inst.s.imm_hi[6], inst.s.imm_lo[0],
			inst.s.imm_hi[5:0], inst.s.imm_lo[4:1], 1'b0};
	assign imm_u = {inst.raw[31:12], 12'b0};
	assign imm_j = {{11{inst.raw[31]}}, inst.raw[31], inst.raw[19:12],
			inst.raw[20], inst.raw[30:21], 1'b0};

	always_comb begin
		dec            = '0;
		dec.pc         = ds_bus.pc;
		dec.op_a       = rs1_data_i;
		dec.op_b       = rs2_data_i;
		dec.store_data = rs2_data_i;
		dec.br_imm     = imm_b;
		dec.alu_op     = ALU_ADD;
		dec.rd         = inst.r.rd;
		case (inst.r.opcode)
			OP_OP: begin
				dec.rf_we = 1'b1;
				case (inst.r.funct3)
					3'b000:  dec.alu_op = inst.r.funct7[5] ? ALU_SUB : ALU_ADD;
					3'b111:  dec.alu_op = ALU_AND;
					3'b110:  dec.alu_op = ALU_OR;
					3'b100:  dec.alu_op = ALU_XOR;
					default: begin
						dec.rf_we     = 1'b0;
						dec.is_ebreak = 1'b1;
					end
				endcase
			end
			// only addi among the immediate ops
			OP_OPIMM: begin
				dec.op_b      = imm_i;
				dec.rf_we     = (inst.i.funct3 == 3'b000);
				dec.is_ebreak = (inst.i.funct3 != 3'b000);
			end
			OP_LUI: begin
				dec.op_b   = imm_u;
				dec.alu_op = ALU_PASS_B;
				dec.rf_we  = 1'b1;
			end
			OP_LOAD: begin
				dec.op_b    = imm_i;
				dec.is_load = 1'b1;
				dec.rf_we   = 1'b1;
			end
			OP_STORE: begin
				dec.op_b     = imm_s;
				dec.is_store = 1'b1;
			end
			OP_BRANCH: begin
				dec.is_branch = (inst.s.funct3 == 3'b000);
				dec.is_ebreak = (inst.s.funct3 != 3'b000);
			end
			// link value comes out of the alu as pc + 4
			OP_JAL: begin
				dec.op_a   = ds_bus.pc;
				dec.op_b   = 32'd4;
				dec.br_imm = imm_j;
				dec.is_jal = 1'b1;
				dec.rf_we  = 1'b1;
			end
			OP_SYSTEM: dec.is_ebreak = 1'b1;
			default:   dec.is_ebreak = 1'b1;
		endcase
	end

	assign ds_to_es_valid_o = ds_valid && ds_ready_go;
	assign ds_to_es_bus_o   = dec;

endmodule

//--- source/cpu_ex_stage.sv
`timescale 1ns/1ns

module cpu_ex_stage import cpu_pkg::*; (
	input  logic          clock,
	input  logic          reset_i,
	input  logic          ds_to_es_valid_i,
	input  ds_to_es_bus_t ds_to_es_bus_i,
	input  logic          ms_allowin_i,
	output logic          es_allowin_o,
	output logic          es_to_ms_valid_o,
	output es_to_ms_bus_t es_to_ms_bus_o
);
	logic          es_valid;
	logic          es_ready_go;
	ds_to_es_bus_t es_bus;
	logic [31:0]   alu_result;
	logic [31:0]   pc_plus4;
	logic [31:0]   pc_target;
	logic          taken;

	assign es_ready_go  = 1'b1;
	assign es_allowin_o = !es_valid || (es_ready_go && ms_allowin_i);

	always_ff @(posedge clock) begin
		if (reset_i) begin
			es_valid <= 1'b0;
		end else if (es_allowin_o) begin
			es_valid <= ds_to_es_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		if (ds_to_es_valid_i && es_allowin_o) begin
			es_bus <= ds_to_es_bus_i;
		end
	end

	always_comb begin
		case (es_bus.alu_op)
			ALU_ADD:    alu_result = es_bus.op_a + es_bus.op_b;
			ALU_SUB:    alu_result = es_bus.op_a - es_bus.op_b;
			ALU_AND:    alu_result = es_bus.op_a & es_bus.op_b;
			ALU_OR:     alu_result = es_bus.op_a | es_bus.op_b;
			ALU_XOR:    alu_result = es_bus.op_a ^ es_bus.op_b;
			ALU_PASS_B: alu_result = es_bus.op_b;
			default:    alu_result = '0;
		endcase
	end

	// beq compares the two register operands
	assign pc_plus4  = es_bus.pc + 32'd4;
	assign pc_target = es_bus.pc + es_bus.br_imm;
	assign taken     = es_bus.is_jal || (es_bus.is_branch && (es_bus.op_a == es_bus.op_b));

	assign es_to_ms_valid_o          = es_valid && es_ready_go;
	assign es_to_ms_bus_o.alu_result = alu_result;
	assign es_to_ms_bus_o.store_data = es_bus.store_data;
	assign es_to_ms_bus_o.next_pc    = taken ? pc_target : pc_plus4;
	assign es_to_ms_bus_o.is_load    = es_bus.is_load;
	assign es_to_ms_bus_o.is_store   = es_bus.is_store;
	assign es_to_ms_bus_o.is_ebreak  = es_bus.is_ebreak;
	assign es_to_ms_bus_o.rd         = es_bus.rd;
	assign es_to_ms_bus_o.rf_we      = es_bus.rf_we;

endmodule

//--- source/cpu_lsu_stage.sv
`timescale 1ns/1ns

module cpu_lsu_stage import cpu_pkg::*; (
	input  logic          clock,
	input  logic          reset_i,
	input  logic          es_to_ms_valid_i,
	input  es_to_ms_bus_t es_to_ms_bus_i,
	input  logic          ws_allowin_i,
	input  logic [31:0]   data_prdata_i,
	input  logic          data_pvalid_i,
	output logic          ms_allowin_o,
	output logic [31:0]   data_paddr_o,
	output logic          data_psel_o,
	output logic          data_pwrite_o,
	output logic [31:0]   data_pwdata_o,
	output logic [3:0]    data_pwstrb_o,
	output logic          ms_to_ws_valid_o,
	output ms_to_ws_bus_t ms_to_ws_bus_o
);
	logic          ms_valid;
	logic          ms_ready_go;
	es_to_ms_bus_t ms_bus;
	logic          mem_op;
	logic          mem_done;
	logic          mem_ack;
	logic [31:0]   rdata_q;
	logic [31:0]   load_data;

	assign mem_op  = ms_bus.is_load || ms_bus.is_store;
	assign mem_ack = data_psel_o && data_pvalid_i;

	// memory ops wait for the port, the rest pass straight through
	assign ms_ready_go  = !mem_op || mem_done || data_pvalid_i;
	assign ms_allowin_o = !ms_valid || (ms_ready_go && ws_allowin_i);

	always_ff @(posedge clock) begin
		if (reset_i) begin
			ms_valid <= 1'b0;
		end else if (ms_allowin_o) begin
			ms_valid <= es_to_ms_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		if (es_to_ms_valid_i && ms_allowin_o) begin
			ms_bus <= es_to_ms_bus_i;
		end
	end

	// keeps the request dropped if writeback is not ready yet
	always_ff @(posedge clock) begin
		if (reset_i) begin
			mem_done <= 1'b0;
		end else if (ms_valid && ms_ready_go && ws_allowin_i) begin
			mem_done <= 1'b0;
		end else if (mem_ack) begin
			mem_done <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (mem_ack) begin
			rdata_q <= data_prdata_i;
		end
	end

	assign load_data = mem_done ? rdata_q : data_prdata_i;

	assign data_psel_o   = ms_valid && mem_op && !mem_done;
	assign data_pwrite_o = ms_valid && ms_bus.is_store && !mem_done;
	assign data_paddr_o  = ms_bus.alu_result;
	assign data_pwdata_o = ms_bus.store_data;
	assign data_pwstrb_o = 4'b1111;

	assign ms_to_ws_valid_o          = ms_valid && ms_ready_go;
	assign ms_to_ws_bus_o.wdata      = ms_bus.is_load ? load_data : ms_bus.alu_result;
	assign ms_to_ws_bus_o.rd         = ms_bus.rd;
	assign ms_to_ws_bus_o.rf_we      = ms_bus.rf_we;
	assign ms_to_ws_bus_o.next_pc    = ms_bus.next_pc;
	assign ms_to_ws_bus_o.is_ebreak  = ms_bus.is_ebreak;

endmodule

//--- source/cpu_wb_stage.sv
`timescale 1ns/1ns

module cpu_wb_stage import cpu_pkg::*; (
	input  logic          clock,
	input  logic          reset_i,
	input  logic          ms_to_ws_valid_i,
	input  ms_to_ws_bus_t ms_to_ws_bus_i,
	output logic          ws_allowin_o,
	output rf_write_t     rf_write_o,
	output ws_to_fs_t     ws_to_fs_o
);
	logic          ws_valid;
	logic          ws_ready_go;
	ms_to_ws_bus_t ws_bus;

	// last stage, retires every cycle
	assign ws_ready_go  = 1'b1;
	assign ws_allowin_o = !ws_valid || ws_ready_go;

	always_ff @(posedge clock) begin
		if (reset_i) begin
			ws_valid <= 1'b0;
		end else if (ws_allowin_o) begin
			ws_valid <= ms_to_ws_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		if (ms_to_ws_valid_i && ws_allowin_o) begin
			ws_bus <= ms_to_ws_bus_i;
		end
	end

	assign rf_write_o.we   = ws_valid && ws_bus.rf_we;
	assign rf_write_o.addr = ws_bus.rd;
	assign rf_write_o.data = ws_bus.wdata;

	// one-cycle retire pulse back to fetch
	assign ws_to_fs_o.redirect = ws_valid && ws_ready_go;
	assign ws_to_fs_o.pc       = ws_bus.next_pc;
	assign ws_to_fs_o.halt     = ws_bus.is_ebreak;

endmodule

//--- source/cpu_regfile.sv
`timescale 1ns/1ns

module cpu_regfile import cpu_pkg::*; (
	input  logic        clock,
	input  logic        reset_i,
	input  rf_write_t   rf_write_i,
	input  logic [4:0]  rs1_addr_i,
	input  logic [4:0]  rs2_addr_i,
	output logic [31:0] rs1_data_o,
	output logic [31:0] rs2_data_o
);
	logic [31:0] regs [31:1];

	always_ff @(posedge clock) begin
		if (reset_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (rf_write_i.we && (rf_write_i.addr != 5'd0)) begin
			regs[rf_write_i.addr] <= rf_write_i.data;
		end
	end

	// x0 is hardwired
	assign rs1_data_o = (rs1_addr_i == 5'd0) ? 32'd0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == 5'd0) ? 32'd0 : regs[rs2_addr_i];

endmodule

//--- source/cpu_top.sv
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  logic        clock,
	input  logic        reset_i,

	// instruction port
	output logic [31:0] inst_paddr_o,
	output logic        inst_psel_o,
	input  logic        inst_pvalid_i,
	input  logic [31:0] inst_prdata_i,

	// data port
	output logic [31:0] data_paddr_o,
	output logic        data_psel_o,
	output logic        data_pwrite_o,
	output logic [31:0] data_pwdata_o,
	output logic [3:0]  data_pwstrb_o,
	input  logic [31:0] data_prdata_i,
	input  logic        data_pvalid_i,

	output logic        halted_o
);
	logic          fs_to_ds_valid;
	fs_to_ds_bus_t fs_to_ds_bus;
	logic          ds_allowin;
	logic          ds_to_es_valid;
	ds_to_es_bus_t ds_to_es_bus;
	logic          es_allowin;
	logic          es_to_ms_valid;
	es_to_ms_bus_t es_to_ms_bus;
	logic          ms_allowin;
	logic          ms_to_ws_valid;
	ms_to_ws_bus_t ms_to_ws_bus;
	logic          ws_allowin;
	ws_to_fs_t     ws_to_fs;
	rf_write_t     rf_write;
	logic [4:0]    rs1_addr;
	logic [4:0]    rs2_addr;
	logic [31:0]   rs1_data;
	logic [31:0]   rs2_data;

	cpu_ifu_stage #(
		.RESET_PC         ( RESET_PC       )
	) u_ifu (
		.clock            ( clock          ),
		.reset_i          ( reset_i        ),
		.ws_to_fs_i       ( ws_to_fs       ),
		.inst_pvalid_i    ( inst_pvalid_i  ),
		.inst_prdata_i    ( inst_prdata_i  ),
		.ds_allowin_i     ( ds_allowin     ),
		.inst_paddr_o     ( inst_paddr_o   ),
		.inst_psel_o      ( inst_psel_o    ),
		.fs_to_ds_valid_o ( fs_to_ds_valid ),
		.fs_to_ds_bus_o   ( fs_to_ds_bus   ),
		.halted_o         ( halted_o       )
	);

	cpu_id_stage u_id (
		.clock            ( clock          ),
		.reset_i          ( reset_i        ),
		.fs_to_ds_valid_i ( fs_to_ds_valid ),
		.fs_to_ds_bus_i   ( fs_to_ds_bus   ),
		.rs1_data_i       ( rs1_data       ),
		.rs2_data_i       ( rs2_data       ),
		.es_allowin_i     ( es_allowin     ),
		.ds_allowin_o     ( ds_allowin     ),
		.rs1_addr_o       ( rs1_addr       ),
		.rs2_addr_o       ( rs2_addr       ),
		.ds_to_es_valid_o ( ds_to_es_valid ),
		.ds_to_es_bus_o   ( ds_to_es_bus   )
	);

	cpu_ex_stage u_ex (
		.clock            ( clock          ),
		.reset_i          ( reset_i        ),
		.ds_to_es_valid_i ( ds_to_es_valid ),
		.ds_to_es_bus_i   ( ds_to_es_bus   ),
		.ms_allowin_i     ( ms_allowin     ),
		.es_allowin_o     ( es_allowin     ),
		.es_to_ms_valid_o ( es_to_ms_valid ),
		.es_to_ms_bus_o   ( es_to_ms_bus   )
	);

	cpu_lsu_stage u_lsu (
		.clock            ( clock          ),
		.reset_i          ( reset_i        ),
		.es_to_ms_valid_i ( es_to_ms_valid ),
		.es_to_ms_bus_i   ( es_to_ms_bus   ),
		.ws_allowin_i     ( ws_allowin     ),
		.data_prdata_i    ( data_prdata_i  ),
		.data_pvalid_i    ( data_pvalid_i  ),
		.ms_allowin_o     ( ms_allowin     ),
		.data_paddr_o     ( data_paddr_o   ),
		.data_psel_o      ( data_psel_o    ),
		.data_pwrite_o    ( data_pwrite_o  ),
		.data_pwdata_o    ( data_pwdata_o  ),
		.data_pwstrb_o    ( data_pwstrb_o  ),
		.ms_to_ws_valid_o ( ms_to_ws_valid ),
		.ms_to_ws_bus_o   ( ms_to_ws_bus   )
	);

	cpu_wb_stage u_wb (
		.clock            ( clock          ),
		.reset_i          ( reset_i        ),
		.ms_to_ws_valid_i ( ms_to_ws_valid ),
		.ms_to_ws_bus_i   ( ms_to_ws_bus   ),
		.ws_allowin_o     ( ws_allowin     ),
		.rf_write_o       ( rf_write       ),
		.ws_to_fs_o       ( ws_to_fs       )
	);

	cpu_regfile u_regfile (
		.clock            ( clock          ),
		.reset_i          ( reset_i        ),
		.rf_write_i       ( rf_write       ),
		.rs1_addr_i       ( rs1_addr       ),
		.rs2_addr_i       ( rs2_addr       ),
		.rs1_data_o       ( rs1_data       ),
		.rs2_data_o       ( rs2_data       )
	);

endmodule

//--- tb/tb_cpu_sva.sv
`timescale 1ns/1ns

module tb_cpu_sva (
	input logic        clock,
	input logic        reset_i,
	input logic        inst_psel_o,
	input logic [31:0] inst_paddr_o,
	input logic        inst_pvalid_i,
	input logic        data_psel_o,
	input logic [31:0] data_paddr_o,
	input logic        data_pvalid_i,
	input logic        data_pwrite_o,
	input logic        halted_o
);
	// request held until the memory answers
	inst_hold: assert property (@(posedge clock) disable iff (reset_i)
		inst_psel_o && !inst_pvalid_i |=> inst_psel_o && $stable(inst_paddr_o))
		else $error("instruction request changed before pvalid");

	data_hold: assert property (@(posedge clock) disable iff (reset_i)
		data_psel_o && !data_pvalid_i |=> data_psel_o && $stable(data_paddr_o))
		else $error("data request changed before pvalid");

	// halt is sticky until reset, no fetch afterwards
	no_fetch_halted: assert property (@(posedge clock) disable iff (reset_i)
		halted_o |=> halted_o && !inst_psel_o)
		else $error("instruction request or halt released after ebreak");

	write_with_sel: assert property (@(posedge clock) disable iff (reset_i)
		data_pwrite_o |-> data_psel_o)
		else $error("pwrite without psel");

endmodule

bind cpu_top tb_cpu_sva u_sva (
	.clock(clock), .reset_i(reset_i),
	.inst_psel_o(inst_psel_o), .inst_paddr_o(inst_paddr_o), .inst_pvalid_i(inst_pvalid_i),
	.data_psel_o(data_psel_o), .data_paddr_o(data_paddr_o), .data_pvalid_i(data_pvalid_i),
	.data_pwrite_o(data_pwrite_o), .halted_o(halted_o)
);

//--- tb/tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu;
	localparam int MAX_CYCLES = 3000;

	logic        clock = 1'b0;
	logic        reset_i = 1'b1;
	logic [31:0] inst_paddr;
	logic        inst_psel;
	logic        inst_pvalid = 1'b0;
	logic [31:0] inst_prdata = 32'd0;
	logic [31:0] data_paddr;
	logic        data_psel;
	logic        data_pwrite;
	logic [31:0] data_pwdata;
	logic [3:0]  data_pwstrb;
	logic [31:0] data_prdata = 32'd0;
	logic        data_pvalid = 1'b0;
	logic        halted;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	logic [31:0] snap [0:1][0:15];
	logic        random_mode = 1'b0;
	logic [31:0] inst_seed = 32'hef8b;
	logic [31:0] data_seed = 32'hef8b;
	logic [2:0]  inst_lat = 3'd1;
	logic [2:0]  data_lat = 3'd1;
	logic [2:0]  inst_cnt = 3'd0;
	logic [2:0]  data_cnt = 3'd0;
	int          cycles = 0;
	int          pc_idx;

	cpu_top #(.RESET_PC(32'h0000_0000)) DUT (
		.clock(clock), .reset_i(reset_i),
		.inst_paddr_o(inst_paddr), .inst_psel_o(inst_psel),
		.inst_pvalid_i(inst_pvalid), .inst_prdata_i(inst_prdata),
		.data_paddr_o(data_paddr), .data_psel_o(data_psel), .data_pwrite_o(data_pwrite),
		.data_pwdata_o(data_pwdata), .data_pwstrb_o(data_pwstrb),
		.data_prdata_i(data_prdata), .data_pvalid_i(data_pvalid), .halted_o(halted)
	);

	always #50 clock = ~clock;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// memory models, pvalid strobes for one cycle after the latency
	always @(posedge clock) begin
		if (reset_i || inst_pvalid) begin
			inst_pvalid <= 1'b0;
			inst_cnt    <= 3'd0;
			inst_seed   <= lcg_next(inst_seed);
			inst_lat    <= random_mode ? 3'd1 + {1'b0, inst_seed[17:16]} : 3'd1;
		end else if (inst_psel) begin
			if (inst_cnt + 3'd1 >= inst_lat) begin
				inst_pvalid <= 1'b1;
				inst_prdata <= imem[inst_paddr[9:2]];
			end else begin
				inst_cnt <= inst_cnt + 3'd1;
			end
		end
	end

	always @(posedge clock) begin
		if (reset_i || data_pvalid) begin
			data_pvalid <= 1'b0;
			data_cnt    <= 3'd0;
			data_seed   <= lcg_next(data_seed);
			data_lat    <= random_mode ? 3'd1 + {1'b0, data_seed[17:16]} : 3'd1;
		end else if (data_psel) begin
			if (data_cnt + 3'd1 >= data_lat) begin
				data_pvalid <= 1'b1;
				if (data_pwrite) begin
					dmem[data_paddr[9:2]] <= data_pwdata;
					// only full-word stores exist
					assert (data_pwstrb === 4'b1111) else begin
						$display("CHECK FAILED data_pwstrb_o got %h expected %h",
								data_pwstrb, 4'b1111);
						fail_run();
					end
				end else begin
					data_prdata <= dmem[data_paddr[9:2]];
				end
			end else begin
				data_cnt <= data_cnt + 3'd1;
			end
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: core did not finish the tests within %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	// instruction encoders
	function automatic logic [31:0] r_op(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic logic [31:0] lw(input logic [4:0] rd, input logic [11:0] off);
		return {off, 5'd0, 3'b010, rd, 7'b0000011};
	endfunction

	function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [11:0] off);
		return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] beq(input logic [4:0] rs1, input logic [4:0] rs2,
			input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	task automatic fail_run();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic emit(input logic [31:0] word);
		imem[pc_idx] = word;
		pc_idx++;
	endtask

	task automatic new_program();
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'h0010_0073;
			dmem[i] = 32'd0;
		end
		pc_idx = 0;
	endtask

	// reset, check the first fetch address and run until ebreak
	task automatic run_program();
		@(posedge clock);
		reset_i <= 1'b1;
		repeat (5) @(posedge clock);
		reset_i <= 1'b0;
		do @(negedge clock); while (!inst_psel);
		assert (inst_paddr == 32'h0000_0000) else begin
			$display("CHECK FAILED inst_paddr_o got %h expected %h", inst_paddr, 32'h0);
			fail_run();
		end
		do @(negedge clock); while (!halted);
	endtask

	task automatic check_word(input int idx, input logic [31:0] exp);
		assert (dmem[idx] === exp) else begin
			$display("CHECK FAILED dmem[%0d] got %h expected %h", idx, dmem[idx], exp);
			fail_run();
		end
	endtask

	task automatic test_alu(input int slot);
		logic [31:0] a;
		logic [31:0] b;
		a = 32'd291;
		b = -32'sd1110;
		new_program();
		emit(addi(1, 0, 12'd291));
		emit(addi(2, 0, -12'sd1110));
		emit(lui(3, 20'habcde));
		emit(r_op(7'h00, 3'b000, 4, 1, 2));
		emit(sw(4, 0));
		emit(r_op(7'h20, 3'b000, 4, 1, 2));
		emit(sw(4, 4));
		emit(r_op(7'h00, 3'b111, 4, 1, 2));
		emit(sw(4, 8));
		emit(r_op(7'h00, 3'b110, 4, 1, 2));
		emit(sw(4, 12));
		emit(r_op(7'h00, 3'b100, 4, 1, 2));
		emit(sw(4, 16));
		emit(sw(3, 20));
		run_program();
		check_word(0, a + b);
		check_word(1, a - b);
		check_word(2, a & b);
		check_word(3, a | b);
		check_word(4, a ^ b);
		check_word(5, 32'habcde000);
		compare_snapshot(slot);
	endtask

	task automatic test_load_store(input int slot);
		logic [31:0] p8;
		logic [31:0] p9;
		new_program();
		p8 = 32'h1357_9bdf;
		p9 = 32'h0246_8ace;
		dmem[8] = p8;
		dmem[9] = p9;
		emit(lw(1, 32));
		emit(lw(2, 36));
		emit(r_op(7'h00, 3'b000, 3, 1, 2));
		emit(sw(3, 40));
		emit(addi(4, 0, 12'h05a));
		emit(sw(4, 44));
		emit(lw(5, 44));
		emit(sw(5, 48));
		run_program();
		check_word(10, p8 + p9);
		check_word(11, 32'h5a);
		check_word(12, 32'h5a);
		compare_snapshot(slot);
	endtask

	// first pass records memory, random pass must match it
	task automatic compare_snapshot(input int slot);
		for (int i = 0; i < 16; i++) begin
			if (!random_mode)
				snap[slot][i] = dmem[i];
			else
				check_word(i, snap[slot][i]);
		end
	endtask

	task automatic test_branch_jal();
		new_program();
		emit(addi(1, 0, 12'd7));
		emit(addi(2, 0, 12'd7));
		emit(beq(1, 2, 13'd12));
		emit(addi(3, 0, 12'd1));
		emit(sw(3, 0));
		emit(addi(4, 0, 12'h011));
		emit(sw(4, 4));
		emit(beq(1, 0, 13'd8));
		emit(addi(5, 0, 12'h022));
		emit(sw(5, 8));
		emit(jal(6, 21'd8));
		emit(sw(1, 12));
		emit(sw(6, 16));
		run_program();
		check_word(0, 32'h0);
		check_word(1, 32'h11);
		check_word(2, 32'h22);
		check_word(3, 32'h0);
		// link is the address after the jal at pc 40
		check_word(4, 32'd44);
	endtask

	task automatic test_x0();
		new_program();
		dmem[0] = 32'hdead_beef;
		dmem[1] = 32'hcafe_f00d;
		emit(addi(0, 0, 12'd5));
		emit(sw(0, 0));
		emit(addi(1, 0, 12'd9));
		emit(r_op(7'h00, 3'b000, 0, 1, 1));
		emit(sw(0, 4));
		emit(r_op(7'h00, 3'b000, 2, 0, 1));
		emit(sw(2, 8));
		run_program();
		check_word(0, 32'h0);
		check_word(1, 32'h0);
		check_word(2, 32'd9);
	endtask

	task automatic test_halt();
		new_program();
		emit(addi(1, 0, 12'd1));
		emit(32'h0010_0073);
		emit(sw(1, 0));
		run_program();
		repeat (50) begin
			@(negedge clock);
			assert (halted && !inst_psel) else begin
				$display("core fetched again or left the halted state after ebreak");
				fail_run();
			end
		end
		check_word(0, 32'h0);
	endtask

	initial begin
		test_alu(0);
		test_load_store(1);
		test_branch_jal();
		test_x0();
		test_halt();
		random_mode = 1'b1;
		test_alu(0);
		test_load_store(1);
		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- tb.f
source/cpu_pkg.sv
source/cpu_ifu_stage.sv
source/cpu_id_stage.sv
source/cpu_ex_stage.sv
source/cpu_lsu_stage.sv
source/cpu_wb_stage.sv
source/cpu_regfile.sv
source/cpu_top.sv
tb/tb_cpu_sva.sv
tb/tb_cpu.sv

//--- Makefile
SRCS := $(wildcard source/*.sv tb/*.sv) tb.f

.PHONY: run clean

obj_dir/Vtb_cpu: $(SRCS)
	verilator --binary --timing --assert -Wall -Wno-fatal --top-module tb_cpu -f tb.f -Mdir obj_dir

run: obj_dir/Vtb_cpu
	./obj_dir/Vtb_cpu | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
